//--- drop_game.f
src/game_pkg.sv
src/drop_ctrl.sv
src/ball_mover.sv
src/slot_store.sv
src/drop_game.sv
sim/drop_game_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the drop_game testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f drop_game.f \
    --top-module drop_game_tb \
    -Mdir obj_dir

output=$(./obj_dir/Vdrop_game_tb)
echo "$output"

if grep -qx "Simulation finished: PASS" <<< "$output"; then
    echo "Result: passed"
    exit 0
else
    echo "Result: failed"
    exit 1
fi

//--- sim/drop_game_tb.sv
`default_nettype none

module drop_game_tb;

    localparam int          ball_total    = 10;
    localparam logic [11:0] home_x        = 12'd170;
    localparam logic [11:0] left_edge     = 12'd100;
    localparam logic [11:0] right_edge    = 12'd240;
    localparam logic [11:0] top_edge      = 12'd20;
    localparam logic [11:0] floor_edge    = 12'd240;
    localparam int          clk_period    = 40;
    localparam int          move_budget   = 400;
    localparam int          fall_budget   = 120;
    localparam int          watchdog_time =
        2 * ball_total * (move_budget + fall_budget) * clk_period;

    // Ball sizes in game order.
    localparam logic [11:0] size_seq [ball_total] = '{
        12'd15, 12'd10, 12'd15, 12'd20, 12'd5,
        12'd10, 12'd15, 12'd20, 12'd10, 12'd15
    };

    logic        clk;
    logic        rst;
    logic        drop;
    logic        left;
    logic        right;
    logic [11:0] slot_x [ball_total];
    logic [11:0] slot_y [ball_total];
    logic [11:0] slot_s [ball_total];
    logic [3:0]  ball_count;
    logic        finish;

    logic [11:0] exp_x  [ball_total];
    logic [11:0] keep_x [ball_total];
    logic [11:0] keep_y [ball_total];
    logic [11:0] keep_s [ball_total];
    logic [11:0] cur_x;
    logic [3:0]  last_count;
    int          errors;
    int          landed;

    drop_game i_drop_game (
        .clk        (clk),
        .rst        (rst),
        .drop       (drop),
        .left       (left),
        .right      (right),
        .slot_x     (slot_x),
        .slot_y     (slot_y),
        .slot_s     (slot_s),
        .ball_count (ball_count),
        .finish     (finish)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // Sideways steps of the player, one per press cycle, stopping at the walls.
    function automatic logic [11:0] expected_x(input logic [11:0] start,
                                               input logic [11:0] size,
                                               input logic        go_right,
                                               input int          presses);
        logic [11:0] x;
        x = start;
        for (int i = 0; i < presses; i++) begin
            if (go_right) begin
                if (x < right_edge - size) begin
                    x = x + 12'd1;
                end
            end else if (x > left_edge + size) begin
                x = x - 12'd1;
            end
        end
        return x;
    endfunction

    task automatic report_mismatch(input string test, input logic [11:0] expected,
                                   input logic [11:0] actual);
        $display("error %s: expected %0d, actual %0d", test, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic hold_move(input int idx, input logic go_right, input int presses);
        left  = !go_right;
        right = go_right;
        repeat (presses) step();
        left  = 1'b0;
        right = 1'b0;
        cur_x = expected_x(cur_x, size_seq[idx], go_right, presses);
    endtask

    task automatic check_reset();
        if (slot_x[0] !== home_x) report_mismatch("reset slot_x[0]", home_x, slot_x[0]);
        if (slot_y[0] !== top_edge - size_seq[0]) begin
            report_mismatch("reset slot_y[0]", top_edge - size_seq[0], slot_y[0]);
        end
        if (slot_s[0] !== size_seq[0]) report_mismatch("reset slot_s[0]", size_seq[0], slot_s[0]);
        for (int i = 1; i < ball_total; i++) begin
            if (slot_x[i] !== 12'd0 || slot_y[i] !== 12'd0 || slot_s[i] !== 12'd0) begin
                report_failure($sformatf("slot %0d was not cleared by reset", i));
            end
        end
        if (finish !== 1'b0) report_failure("finish is high right after reset");
        if (ball_count !== 4'd0) report_mismatch("reset ball_count", 12'd0, 12'(ball_count));
    endtask

    task automatic play_ball(input int idx);
        logic go_right;
        int   presses;
        go_right = ($urandom_range(1, 0) == 1);
        presses  = $urandom_range(120, 0);
        hold_move(idx, go_right, presses);
        exp_x[idx] = cur_x;
        drop = 1'b1;
        step();
        drop = 1'b0;
        while (ball_count == 4'(idx)) step();  // Watchdog guards a fall that never ends.
        cur_x = home_x;
        step();
        if (idx + 1 < ball_total && slot_x[idx + 1] !== home_x) begin
            report_mismatch($sformatf("next ball %0d x", idx + 1), home_x, slot_x[idx + 1]);
        end
    endtask

    task automatic check_finish();
        if (finish !== 1'b1) report_failure("finish is low after the last ball landed");
        for (int i = 0; i < ball_total; i++) begin
            keep_x[i] = slot_x[i];
            keep_y[i] = slot_y[i];
            keep_s[i] = slot_s[i];
        end
        drop = 1'b1;
        step();
        drop = 1'b0;
        left = 1'b1;
        repeat (fall_budget) step();             // Long enough for a full fall.
        left = 1'b0;
        step();
        for (int i = 0; i < ball_total; i++) begin
            if (slot_x[i] !== keep_x[i] || slot_y[i] !== keep_y[i] || slot_s[i] !== keep_s[i]) begin
                report_failure($sformatf("slot %0d changed after the game finished", i));
            end
        end
        if (ball_count !== 4'd10) report_mismatch("final ball_count", 12'd10, 12'(ball_count));
    endtask

    // Slot of the ball that just landed.
    task automatic check_landed(input logic [3:0] idx);
        logic [11:0] size;
        size = size_seq[idx];
        landed++;
        if (ball_count !== idx + 4'd1) begin
            report_failure($sformatf("ball_count jumped from %0d to %0d", idx, ball_count));
        end
        if (slot_x[idx] !== exp_x[idx]) begin
            report_mismatch($sformatf("landed x ball %0d", idx), exp_x[idx], slot_x[idx]);
        end
        if (slot_y[idx] !== floor_edge - size) begin
            report_mismatch($sformatf("landed y ball %0d", idx), floor_edge - size, slot_y[idx]);
        end
        if (slot_s[idx] !== size) begin
            report_mismatch($sformatf("landed size ball %0d", idx), size, slot_s[idx]);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            last_count = 4'd0;
        end else if (ball_count != last_count) begin
            check_landed(last_count);
            last_count = ball_count;
        end
    end

    initial begin
        void'($urandom(25032));
        rst    = 1'b1;
        drop   = 1'b0;
        left   = 1'b0;
        right  = 1'b0;
        errors = 0;
        landed = 0;
        cur_x  = home_x;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        step();
        check_reset();

        hold_move(0, 1'b0, 200);
        step();
        step();                                  // Slot lags the live ball by one cycle.
        if (slot_x[0] !== left_edge + size_seq[0]) begin
            report_mismatch("left saturation", left_edge + size_seq[0], slot_x[0]);
        end

        hold_move(0, 1'b1, 200);
        step();
        step();
        if (slot_x[0] !== right_edge - size_seq[0]) begin
            report_mismatch("right saturation", right_edge - size_seq[0], slot_x[0]);
        end

        for (int i = 0; i < ball_total; i++) begin
            play_ball(i);
        end
        check_finish();

        if (landed != ball_total) begin
            report_failure($sformatf("only %0d of %0d balls landed", landed, ball_total));
        end
        $display("Balls checked: %0d, errors: %0d", landed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("Watchdog expired after %0d time units, the game did not complete",
                 watchdog_time);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/ball_mover.sv
`default_nettype none

module ball_mover #(
    parameter game_pkg::coord_t fall_step = 12'd3,
    parameter game_pkg::coord_t start_x   = 12'd170
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  left,
    input  logic                  right,
    input  game_pkg::game_state_e state,
    input  game_pkg::coord_t      ball_size,
    output game_pkg::coord_t      x_pos,
    output game_pkg::coord_t      y_pos,
    output logic                  at_floor
);
    import game_pkg::*;

    coord_t top_y;
    coord_t rest_y;
    coord_t min_x;
    coord_t max_x;

    assign top_y  = up_bound - ball_size;
    assign rest_y = floor_y - ball_size;       // Resting height on the floor.
    assign min_x  = left_bound + ball_size;
    assign max_x  = right_bound - ball_size;

    assign at_floor = (y_pos == rest_y);

    always_ff @(posedge clk) begin
        if (rst) begin
            x_pos <= start_x;
            y_pos <= top_y;
        end else begin
            case (state)
                st_select: begin
                    y_pos <= top_y;
                    if (left) begin
                        if (x_pos != min_x) begin
                            x_pos <= x_pos - 1'b1;
                        end
                    end else if (right) begin
                        if (x_pos != max_x) begin
                            x_pos <= x_pos + 1'b1;
                        end
                    end
                end
                st_falling: begin
                    if (y_pos + fall_step >= rest_y) begin
                        y_pos <= rest_y;           // Clamp on the floor.
                    end else begin
                        y_pos <= y_pos + fall_step;
                    end
                end
                default: begin
                    x_pos <= start_x;              // New ball at the start column.
                    y_pos <= top_y;
                end
            endcase
        end
    end

    // Also holds across the size change when the next ball appears.
    y_above_floor: assert property (
        @(posedge clk) disable iff (rst)
        y_pos <= rest_y
    ) else $error("ball fell through the floor");

endmodule

`default_nettype wire

//--- src/drop_ctrl.sv
`default_nettype none

module drop_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  drop,
    input  logic                  at_floor,
    output game_pkg::game_state_e state,
    output game_pkg::count_t      ball_index,
    output game_pkg::coord_t      ball_size,
    output logic                  slot_we,
    output logic                  finish
);
    import game_pkg::*;

    count_t      count;
    game_state_e state_next;

    assign finish     = (count == count_t'(num_balls));
    assign slot_we    = !finish;                       // Store follows the live ball.
    assign ball_index = count;

    // No ball in play once all have landed.
    always_comb begin
        if (finish) begin
            ball_size = '0;
        end else begin
            ball_size = ball_size_table[count];
        end
    end

    always_comb begin
        case (state)
            st_select: begin
                if (drop && !finish) begin             // Drops after the game are ignored.
                    state_next = st_falling;
                end else begin
                    state_next = st_select;
                end
            end
            st_falling: begin
                if (at_floor) begin
                    state_next = st_landed;
                end else begin
                    state_next = st_falling;
                end
            end
            st_landed: begin
                state_next = st_select;
            end
            default: begin
                state_next = st_select;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_select;
            count <= '0;
        end else begin
            state <= state_next;
            if (state == st_landed) begin
                count <= count + 1'b1;                 // Next ball.
            end
        end
    end

    count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        count <= count_t'(num_balls)
    ) else $error("ball counter passed num_balls");

    landed_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        state == st_landed |=> state != st_landed
    ) else $error("st_landed held for two cycles");

endmodule

`default_nettype wire

//--- src/drop_game.sv
`default_nettype none

module drop_game #(
    parameter game_pkg::coord_t fall_step = 12'd3,
    parameter game_pkg::coord_t start_x   = 12'd170
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             drop,
    input  logic             left,
    input  logic             right,
    output game_pkg::coord_t slot_x [game_pkg::num_balls],
    output game_pkg::coord_t slot_y [game_pkg::num_balls],
    output game_pkg::coord_t slot_s [game_pkg::num_balls],
    output game_pkg::count_t ball_count,
    output logic             finish
);
    import game_pkg::*;

    game_state_e state;
    coord_t      ball_size;
    coord_t      x_pos;
    coord_t      y_pos;
    logic        slot_we;
    logic        at_floor;

    // The ball counter doubles as the slot index.
    drop_ctrl i_drop_ctrl (
        .clk        (clk),
        .rst        (rst),
        .drop       (drop),
        .at_floor   (at_floor),
        .state      (state),
        .ball_index (ball_count),
        .ball_size  (ball_size),
        .slot_we    (slot_we),
        .finish     (finish)
    );

    ball_mover #(
        .fall_step (fall_step),
        .start_x   (start_x)
    ) i_ball_mover (
        .clk       (clk),
        .rst       (rst),
        .left      (left),
        .right     (right),
        .state     (state),
        .ball_size (ball_size),
        .x_pos     (x_pos),
        .y_pos     (y_pos),
        .at_floor  (at_floor)
    );

    slot_store i_slot_store (
        .clk        (clk),
        .rst        (rst),
        .slot_we    (slot_we),
        .ball_index (ball_count),
        .x_pos      (x_pos),
        .y_pos      (y_pos),
        .ball_size  (ball_size),
        .slot_x     (slot_x),
        .slot_y     (slot_y),
        .slot_s     (slot_s)
    );

endmodule

`default_nettype wire

//--- src/game_pkg.sv
`default_nettype none

package game_pkg;

    // Pixel coordinate or ball size.
    typedef logic [11:0] coord_t;

    // Ball counter, holds 0 to num_balls.
    typedef logic [3:0] count_t;

    localparam int num_balls = 10;

    // Play field edges in pixels.
    localparam coord_t left_bound  = 12'd100;
    localparam coord_t right_bound = 12'd240;
    localparam coord_t up_bound    = 12'd20;
    localparam coord_t floor_y     = 12'd240;

    typedef enum logic [1:0] {
        st_select,   // Ball at the top, player moves it.
        st_falling,  // Ball drops toward the floor.
        st_landed    // One cycle, advance to the next ball.
    } game_state_e;

    // Size of each ball, by ball index.
    localparam coord_t ball_size_table [num_balls] = '{
        12'd15,
        12'd10,
        12'd15,
        12'd20,
        12'd5,
        12'd10,
        12'd15,
        12'd20,
        12'd10,
        12'd15
    };

endpackage

`default_nettype wire

//--- src/slot_store.sv
`default_nettype none

module slot_store (
    input  logic             clk,
    input  logic             rst,
    input  logic             slot_we,
    input  game_pkg::count_t ball_index,
    input  game_pkg::coord_t x_pos,
    input  game_pkg::coord_t y_pos,
    input  game_pkg::coord_t ball_size,
    output game_pkg::coord_t slot_x [game_pkg::num_balls],
    output game_pkg::coord_t slot_y [game_pkg::num_balls],
    output game_pkg::coord_t slot_s [game_pkg::num_balls]
);
    import game_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_balls; i++) begin
                slot_x[i] <= '0;
                slot_y[i] <= '0;
                slot_s[i] <= '0;
            end
        end else if (slot_we) begin
            slot_x[ball_index] <= x_pos;       // Tracks the live ball every cycle.
            slot_y[ball_index] <= y_pos;
            slot_s[ball_index] <= ball_size;
        end
    end

    // The controller must stop writing once the last slot is used.
    index_valid: assert property (
        @(posedge clk) disable iff (rst)
        slot_we |-> ball_index < count_t'(num_balls)
    ) else $error("slot write past the last ball");

endmodule

`default_nettype wire
